/* Makefile */
TOP := obi_support_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

obj_dir/V$(TOP): project.f rtl/*.sv testbench/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

/* project.f */
rtl/obi_pkg.sv
rtl/trap_pkg.sv
rtl/obi_phase_tracker.sv
rtl/req_attr_fifo.sv
rtl/resp_attr_tagger.sv
rtl/trap_req_monitor.sv
rtl/obi_support_top.sv
testbench/tb_clock_gen.sv
testbench/obi_support_assertions.sv
testbench/obi_support_tb.sv

/* rtl/obi_phase_tracker.sv */
// ------------------------------------------------------------
// OBI phase tracker
// flags continued address and response phases, tracks the
// grant parity error and forms the attribute word per request
// ------------------------------------------------------------
`default_nettype none

module obi_phase_tracker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               gnt_i,
  input  logic               gntpar_i,
  input  logic               rready_i,
  input  logic               rvalid_i,
  input  logic               we_i,
  input  logic               integrity_i,
  output logic               addr_ph_cont_o,
  output logic               resp_ph_cont_o,
  output logic               push_o,
  output obi_pkg::obi_attr_t push_attr_o
);

  import obi_pkg::*;

  logic gnt_err;
  logic gnt_err_q;

  // parity of gnt must differ from gnt, an earlier miss in the
  // same address phase is held in gnt_err_q
  assign gnt_err = req_i && ((gntpar_i == gnt_i) || gnt_err_q);

  // address handshake
  assign push_o = req_i && gnt_i;

  always_comb begin
    push_attr_o                 = '0;
    push_attr_o[ATTR_STORE]     = we_i;
    push_attr_o[ATTR_INTEGRITY] = integrity_i;
    push_attr_o[ATTR_GNT_ERR]   = gnt_err;
  end

  // ------------------------------------------------------------
  // continued phase flags and error carry
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cont_o <= 1'b0;
      resp_ph_cont_o <= 1'b0;
      gnt_err_q      <= 1'b0;
    end else begin
      addr_ph_cont_o <= req_i && !gnt_i;
      resp_ph_cont_o <= rvalid_i && !rready_i;
      // keep the error only while the address phase is stalled
      if (req_i && !gnt_i) begin
        gnt_err_q <= gnt_err;
      end else begin
        gnt_err_q <= 1'b0;
      end
    end
  end

endmodule : obi_phase_tracker

`default_nettype wire

/* rtl/obi_pkg.sv */
// ------------------------------------------------------------
// OBI bus package
// request attribute word, outstanding count and the bit
// positions of each attribute recorded at the handshake
// ------------------------------------------------------------
`default_nettype none

package obi_pkg;

  // ------------------------------------------------------------
  // attribute word
  // ------------------------------------------------------------

  // one bit per recorded request attribute
  typedef logic [2:0] obi_attr_t;

  // request is a store (we high at the handshake)
  localparam int unsigned ATTR_STORE     = 0;
  // request carries integrity
  localparam int unsigned ATTR_INTEGRITY = 1;
  // grant parity error seen during the address phase
  localparam int unsigned ATTR_GNT_ERR   = 2;

  // ------------------------------------------------------------
  // outstanding count
  // ------------------------------------------------------------

  // wide enough for buffer depths up to 15
  typedef logic [3:0] obi_cnt_t;

endpackage : obi_pkg

`default_nettype wire

/* rtl/obi_support_top.sv */
// ------------------------------------------------------------
// OBI checker support top
// passive monitor of one data bus, phase flags, per-request
// attributes at the response, protocol and trap checks
// ------------------------------------------------------------
`default_nettype none

module obi_support_top #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // OBI bus
  input  logic              req_i,
  input  logic              gnt_i,
  input  logic              gntpar_i,
  input  logic              rready_i,
  input  logic              rvalid_i,
  input  logic              we_i,
  input  logic              integrity_i,
  // core control
  input  logic              pc_set_i,
  input  trap_pkg::pc_mux_t pc_mux_i,
  input  logic              retire_i,
  // checker outputs
  output logic              addr_ph_cont_o,
  output logic              resp_ph_cont_o,
  output logic              store_in_resp_o,
  output logic              integrity_in_resp_o,
  output logic              gnt_err_in_resp_o,
  output logic              orphan_resp_o,
  output obi_pkg::obi_cnt_t outstanding_o,
  output logic              overflow_o,
  output logic              req_after_trap_o
);

  import obi_pkg::*;

  logic      push;
  obi_attr_t push_attr;
  logic      pop;
  obi_attr_t head_attr;

  // ------------------------------------------------------------
  // attribute path
  // ------------------------------------------------------------
  obi_phase_tracker phase_tracker_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .gnt_i          (gnt_i),
    .gntpar_i       (gntpar_i),
    .rready_i       (rready_i),
    .rvalid_i       (rvalid_i),
    .we_i           (we_i),
    .integrity_i    (integrity_i),
    .addr_ph_cont_o (addr_ph_cont_o),
    .resp_ph_cont_o (resp_ph_cont_o),
    .push_o         (push),
    .push_attr_o    (push_attr)
  );

  req_attr_fifo #(
    .FifoDepth (FifoDepth)
  ) attr_fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_attr_i (push_attr),
    .pop_i       (pop),
    .head_attr_o (head_attr),
    .count_o     (outstanding_o),
    .overflow_o  (overflow_o)
  );

  resp_attr_tagger attr_tagger_i (
    .rvalid_i            (rvalid_i),
    .rready_i            (rready_i),
    .head_attr_i         (head_attr),
    .count_i             (outstanding_o),
    .pop_o               (pop),
    .store_in_resp_o     (store_in_resp_o),
    .integrity_in_resp_o (integrity_in_resp_o),
    .gnt_err_in_resp_o   (gnt_err_in_resp_o),
    .orphan_resp_o       (orphan_resp_o)
  );

  // trap check uses the address handshake
  trap_req_monitor trap_monitor_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .retire_i         (retire_i),
    .handshake_i      (push),
    .req_after_trap_o (req_after_trap_o)
  );

endmodule : obi_support_top

`default_nettype wire

/* rtl/req_attr_fifo.sv */
// ------------------------------------------------------------
// Request attribute buffer
// in-order store of request attributes with outstanding count
// and a sticky overflow flag
// ------------------------------------------------------------
`default_nettype none

module req_attr_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  obi_pkg::obi_attr_t push_attr_i,
  input  logic               pop_i,
  output obi_pkg::obi_attr_t head_attr_o,
  output obi_pkg::obi_cnt_t  count_o,
  output logic               overflow_o
);

  import obi_pkg::*;

  localparam int unsigned PtrW = $clog2(FifoDepth);

  obi_attr_t        mem_q [FifoDepth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  obi_cnt_t         count_q;
  logic             full;
  logic             push_ok;

  // circular increment over FifoDepth entries
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full        = (count_q == obi_cnt_t'(FifoDepth));
  assign push_ok     = push_i && !full;
  assign head_attr_o = mem_q[rd_ptr_q];
  assign count_o     = count_q;

  // storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_attr_i;
    end
  end

  // ------------------------------------------------------------
  // pointers, count and overflow
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      // pop is only issued with a nonzero count
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_ok, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // a push into a full buffer is lost
      if (push_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule : req_attr_fifo

`default_nettype wire

/* rtl/resp_attr_tagger.sv */
// ------------------------------------------------------------
// Response attribute tagger
// pops the buffer on a response, presents the recorded bits
// and flags responses with nothing outstanding
// ------------------------------------------------------------
`default_nettype none

module resp_attr_tagger (
  input  logic               rvalid_i,
  input  logic               rready_i,
  input  obi_pkg::obi_attr_t head_attr_i,
  input  obi_pkg::obi_cnt_t  count_i,
  output logic               pop_o,
  output logic               store_in_resp_o,
  output logic               integrity_in_resp_o,
  output logic               gnt_err_in_resp_o,
  output logic               orphan_resp_o
);

  import obi_pkg::*;

  logic resp;
  logic has_entry;

  assign resp      = rvalid_i && rready_i;
  assign has_entry = (count_i != '0);

  assign pop_o         = resp && has_entry;
  assign orphan_resp_o = resp && !has_entry;

  // attributes of the oldest request, low on an orphan response
  assign store_in_resp_o     = pop_o && head_attr_i[ATTR_STORE];
  assign integrity_in_resp_o = pop_o && head_attr_i[ATTR_INTEGRITY];
  assign gnt_err_in_resp_o   = pop_o && head_attr_i[ATTR_GNT_ERR];

endmodule : resp_attr_tagger

`default_nettype wire

/* rtl/trap_pkg.sv */
// ------------------------------------------------------------
// Core control package
// pc mux code type, the trap codes and the trap monitor states
// ------------------------------------------------------------
`default_nettype none

package trap_pkg;

  // program counter source select
  typedef logic [2:0] pc_mux_t;

  // sources that count as a trap
  localparam pc_mux_t PC_TRAP_EXC = 3'd4;
  localparam pc_mux_t PC_TRAP_DBE = 3'd5;

  // trap monitor FSM
  typedef enum logic {
    TRAP_IDLE,
    TRAP_ACTIVE
  } trap_state_e;

endpackage : trap_pkg

`default_nettype wire

/* rtl/trap_req_monitor.sv */
// ------------------------------------------------------------
// Trap request monitor
// raises a level when a data request is accepted after a trap
// and before the next retirement
// ------------------------------------------------------------
`default_nettype none

module trap_req_monitor (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              pc_set_i,
  input  trap_pkg::pc_mux_t pc_mux_i,
  input  logic              retire_i,
  input  logic              handshake_i,
  output logic              req_after_trap_o
);

  import trap_pkg::*;

  trap_state_e state_q;
  trap_state_e state_d;
  logic        trap;

  assign trap = pc_set_i && (pc_mux_i == PC_TRAP_EXC || pc_mux_i == PC_TRAP_DBE);

  // a trap takes priority over a retire in the same cycle
  always_comb begin
    state_d = state_q;
    if (trap) begin
      state_d = TRAP_ACTIVE;
    end else if (retire_i) begin
      state_d = TRAP_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= TRAP_IDLE;
      req_after_trap_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (trap) begin
        // handshake in the trap cycle itself counts
        if (handshake_i) begin
          req_after_trap_o <= 1'b1;
        end
      end else if (retire_i) begin
        req_after_trap_o <= 1'b0;
      end else if (state_q == TRAP_ACTIVE && handshake_i) begin
        req_after_trap_o <= 1'b1;
      end
    end
  end

endmodule : trap_req_monitor

`default_nettype wire

/* testbench/obi_support_assertions.sv */
// ------------------------------------------------------------
// OBI checker support assertions
// phase flags, orphan responses, sticky overflow and trap rule
// ------------------------------------------------------------
`default_nettype none

module obi_support_assertions (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              gnt_i,
  input  logic              rvalid_i,
  input  logic              rready_i,
  input  logic              pc_set_i,
  input  trap_pkg::pc_mux_t pc_mux_i,
  input  logic              retire_i,
  input  logic              addr_cont_i,
  input  logic              resp_cont_i,
  input  logic              orphan_i,
  input  logic              resp_store_i,
  input  logic              resp_integrity_i,
  input  logic              resp_gnt_err_i,
  input  logic              overflow_i,
  input  logic              req_after_trap_i
);

  import trap_pkg::*;

  int unsigned fail_cnt = 0;
  logic        trap;
  logic        trap_seen_q;

  assign trap = pc_set_i && (pc_mux_i == PC_TRAP_EXC || pc_mux_i == PC_TRAP_DBE);

  // trap seen and not yet retired
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_seen_q <= 1'b0;
    end else if (trap) begin
      trap_seen_q <= 1'b1;
    end else if (retire_i) begin
      trap_seen_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // bus checks
  // ------------------------------------------------------------
  addr_cont_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_i |=> addr_cont_i)
    else begin $error("stalled address phase not flagged"); fail_cnt++; end

  resp_cont_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i && !rready_i |=> resp_cont_i)
    else begin $error("stalled response phase not flagged"); fail_cnt++; end

  orphan_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    orphan_i |-> rvalid_i && rready_i && !resp_store_i && !resp_integrity_i && !resp_gnt_err_i)
    else begin $error("orphan response with attributes or without handshake"); fail_cnt++; end

  overflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    overflow_i |=> overflow_i)
    else begin $error("overflow flag dropped"); fail_cnt++; end

  // ------------------------------------------------------------
  // trap checks
  // ------------------------------------------------------------
  trap_set_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && gnt_i && (trap || (trap_seen_q && !retire_i)) |=> req_after_trap_i)
    else begin $error("request after trap not flagged"); fail_cnt++; end

  trap_clr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_i && !trap |=> !req_after_trap_i)
    else begin $error("retire did not clear the trap level"); fail_cnt++; end

  trap_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trap && retire_i && req_after_trap_i |=> req_after_trap_i)
    else begin $error("trap with retire cleared the trap level"); fail_cnt++; end

endmodule : obi_support_assertions

bind obi_support_top obi_support_assertions checks_i (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .req_i            (req_i),
  .gnt_i            (gnt_i),
  .rvalid_i         (rvalid_i),
  .rready_i         (rready_i),
  .pc_set_i         (pc_set_i),
  .pc_mux_i         (pc_mux_i),
  .retire_i         (retire_i),
  .addr_cont_i      (addr_ph_cont_o),
  .resp_cont_i      (resp_ph_cont_o),
  .orphan_i         (orphan_resp_o),
  .resp_store_i     (store_in_resp_o),
  .resp_integrity_i (integrity_in_resp_o),
  .resp_gnt_err_i   (gnt_err_in_resp_o),
  .overflow_i       (overflow_o),
  .req_after_trap_i (req_after_trap_o)
);

`default_nettype wire

/* testbench/obi_support_tb.sv */
// ------------------------------------------------------------
// OBI checker support testbench
// drives bus and core control, keeps a queue model of the
// outstanding attributes and reports the result
// ------------------------------------------------------------
`default_nettype none

module obi_support_tb;

  import obi_pkg::*;
  import trap_pkg::*;

  localparam int unsigned FifoDepth  = 4;
  localparam int unsigned RandCycles = 300;
  // directed part is under 100 cycles and the rest is margin
  localparam int unsigned MaxCycles  = 2000;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        gnt;
  logic        gntpar;
  logic        rready;
  logic        rvalid;
  logic        we;
  logic        integrity;
  logic        pc_set;
  pc_mux_t     pc_mux;
  logic        retire;
  logic        addr_ph_cont;
  logic        resp_ph_cont;
  logic        store_in_resp;
  logic        integrity_in_resp;
  logic        gnt_err_in_resp;
  logic        orphan_resp;
  obi_cnt_t    outstanding;
  logic        overflow;
  logic        req_after_trap;

  obi_attr_t   model_q [$];
  logic        ovf_exp;
  logic        err_hold;
  logic [31:0] rng;
  int unsigned cycle_cnt;
  string       test_name;

  tb_clock_gen #(.Period(8), .ResetCycles(4)) clock_gen_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  obi_support_top #(.FifoDepth(FifoDepth)) dut_i (
    .clk_i (clk), .rst_ni (rst_n),
    .req_i (req), .gnt_i (gnt), .gntpar_i (gntpar),
    .rready_i (rready), .rvalid_i (rvalid), .we_i (we), .integrity_i (integrity),
    .pc_set_i (pc_set), .pc_mux_i (pc_mux), .retire_i (retire),
    .addr_ph_cont_o (addr_ph_cont), .resp_ph_cont_o (resp_ph_cont),
    .store_in_resp_o (store_in_resp), .integrity_in_resp_o (integrity_in_resp),
    .gnt_err_in_resp_o (gnt_err_in_resp), .orphan_resp_o (orphan_resp),
    .outstanding_o (outstanding), .overflow_o (overflow),
    .req_after_trap_o (req_after_trap)
  );

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_val(input string what, input int unsigned exp, input int unsigned act);
    if (exp != act) begin
      fail_stop($sformatf("error %s %s: expected %0h, actual %0h", test_name, what, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic set_bus(input logic req_v, input logic gnt_v, input logic par_v,
                         input logic we_v, input logic integ_v,
                         input logic rvalid_v, input logic rready_v);
    req       = req_v;
    gnt       = gnt_v;
    gntpar    = par_v;
    we        = we_v;
    integrity = integ_v;
    rvalid    = rvalid_v;
    rready    = rready_v;
  endtask

  task automatic bus_cycle(input logic req_v, input logic gnt_v, input logic par_v,
                           input logic we_v, input logic integ_v,
                           input logic rvalid_v, input logic rready_v);
    next_edge();
    set_bus(req_v, gnt_v, par_v, we_v, integ_v, rvalid_v, rready_v);
  endtask

  task automatic ctrl_set(input logic pc_set_v, input pc_mux_t mux_v, input logic retire_v);
    pc_set = pc_set_v;
    pc_mux = mux_v;
    retire = retire_v;
  endtask

  // responder with random stalls that never fills past the buffer depth
  task automatic random_cycle();
    logic req_v;
    logic gnt_v;
    next_edge();
    rng   = xorshift32(rng);
    req_v = rng[0] && (model_q.size() < FifoDepth);
    gnt_v = rng[1] || rng[2];
    set_bus(req_v, gnt_v, (rng[7:3] == '0) ? gnt_v : !gnt_v, rng[11], rng[12],
            rng[8] && (model_q.size() != 0), rng[9] || rng[10]);
  endtask

  task automatic drain();
    next_edge();
    while (model_q.size() != 0) begin
      set_bus(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
      next_edge();
    end
    set_bus(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // ------------------------------------------------------------
  // reference model sampled mid cycle
  // ------------------------------------------------------------
  task automatic model_step();
    obi_attr_t exp_attr;
    obi_attr_t act_attr;
    logic      full;
    logic      err_now;
    if (dut_i.checks_i.fail_cnt != 0) begin
      fail_stop($sformatf("a bound assertion failed during test %s", test_name));
    end
    check_val("outstanding_o", model_q.size(), outstanding);
    check_val("overflow_o", ovf_exp, overflow);
    full    = (model_q.size() == FifoDepth);
    err_now = req && ((gntpar == gnt) || err_hold);
    act_attr                 = '0;
    act_attr[ATTR_STORE]     = store_in_resp;
    act_attr[ATTR_INTEGRITY] = integrity_in_resp;
    act_attr[ATTR_GNT_ERR]   = gnt_err_in_resp;
    if (rvalid && rready) begin
      if (model_q.size() != 0) begin
        exp_attr = model_q.pop_front();
        check_val("resp attributes", exp_attr, act_attr);
        check_val("orphan_resp_o", 0, orphan_resp);
      end else begin
        check_val("orphan_resp_o", 1, orphan_resp);
        check_val("resp attributes", 0, act_attr);
      end
    end
    if (req && gnt) begin
      if (full) begin
        ovf_exp = 1'b1;
      end else begin
        exp_attr                 = '0;
        exp_attr[ATTR_STORE]     = we;
        exp_attr[ATTR_INTEGRITY] = integrity;
        exp_attr[ATTR_GNT_ERR]   = err_now;
        model_q.push_back(exp_attr);
      end
    end
    err_hold = (req && !gnt) ? err_now : 1'b0;
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      model_step();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > MaxCycles) begin
      fail_stop($sformatf("timeout after %0d cycles in test %s", MaxCycles, test_name));
    end
  end

  initial begin
    set_bus(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    ctrl_set(1'b0, '0, 1'b0);
    ovf_exp   = 1'b0;
    err_hold  = 1'b0;
    cycle_cnt = 0;
    rng       = 32'd61732;
    test_name = "reset";
    wait (rst_n);

    // parity error in the first stall cycle only and then a stalled response
    test_name = "phase_stall";
    bus_cycle(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    bus_cycle(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);

    test_name = "random";
    repeat (RandCycles) random_cycle();
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    drain();

    test_name = "orphan";
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);

    test_name = "trap";
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    ctrl_set(1'b1, PC_TRAP_EXC, 1'b0);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    ctrl_set(1'b0, '0, 1'b1);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    ctrl_set(1'b1, PC_TRAP_DBE, 1'b0);
    // handshake while the monitor is active
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    ctrl_set(1'b0, '0, 1'b0);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    ctrl_set(1'b1, PC_TRAP_EXC, 1'b1);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    ctrl_set(1'b0, '0, 1'b1);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    ctrl_set(1'b0, '0, 1'b0);
    drain();

    test_name = "overflow";
    repeat (FifoDepth + 1) bus_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    // idle cycles so the sticky flag has to hold
    repeat (3) bus_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    check_val("overflow_o", 1, overflow);
    next_edge();

    if (dut_i.checks_i.fail_cnt == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_stop("a bound assertion failed in the last cycle");
    end
  end

endmodule : obi_support_tb

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// ------------------------------------------------------------
// Testbench clock and reset generator
// ------------------------------------------------------------
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned Period      = 8,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // release just after an edge, like every other input
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire
